/* source/axi_regs_pkg.sv */
`default_nettype none

package axi_regs_pkg;

	localparam int addr_width = 4; // byte address of the register window.
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;
	localparam int reg_count = 4;

	// one credit per buffer slot, so the two numbers are the same.
	localparam int wr_buf_depth = 4;
	localparam int credit_width = 3; // holds 0 to wr_buf_depth.

	localparam logic [1:0] axi_resp_okay = 2'b00;

	// word index, taken from address bits 3..2.
	typedef logic [1:0] reg_index_t;

	typedef struct packed {
		reg_index_t index;
		logic [data_width-1:0] data;
		logic [strb_width-1:0] strb;
	} write_req_t;

endpackage

`default_nettype wire

/* source/axi_write_front.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_write_front
	import axi_regs_pkg::*;
(
	input wire logic s00_axi_aclk,
	input wire logic arst_n,
	input wire logic [addr_width-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [data_width-1:0] wdata,
	input wire logic [strb_width-1:0] wstrb,
	input wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic commit,
	output write_req_t wr_req,
	output logic push
);

	logic aw_full;
	logic w_full;
	reg_index_t aw_index;
	logic [data_width-1:0] w_data;
	logic [strb_width-1:0] w_strb;

	logic [credit_width-1:0] credits;
	logic [credit_width-1:0] pending;

	logic have_credit;
	logic aw_hs;
	logic w_hs;
	logic b_hs;

	assign have_credit = (credits != '0);
	assign awready = !aw_full && have_credit;
	assign wready = !w_full && have_credit;

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign b_hs = bvalid && bready;

	// a request leaves as soon as both halves are held.
	assign push = aw_full && w_full;
	assign wr_req = '{index: aw_index, data: w_data, strb: w_strb};

	assign bvalid = (pending != '0);
	assign bresp = axi_resp_okay;

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			aw_full <= 1'b0;
			w_full <= 1'b0;
		end else begin
			if (push) begin
				aw_full <= 1'b0;
				w_full <= 1'b0;
			end else begin
				if (aw_hs)
					aw_full <= 1'b1;
				if (w_hs)
					w_full <= 1'b1;
			end
		end
	end

	// address bits 1..0 are dropped, accesses are word aligned.
	always_ff @(posedge s00_axi_aclk) begin
		if (aw_hs)
			aw_index <= reg_index_t'(awaddr[addr_width-1:2]);
		if (w_hs) begin
			w_data <= wdata;
			w_strb <= wstrb;
		end
	end

	// a credit is spent on push and comes back with the B handshake.
	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= credit_width'(wr_buf_depth);
		end else begin
			case ({push, b_hs})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
		end else begin
			case ({commit, b_hs})
				2'b10: pending <= pending + 1'b1;
				2'b01: pending <= pending - 1'b1;
				default: pending <= pending;
			endcase
		end
	end

	a_credit_bound: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		credits <= credit_width'(wr_buf_depth));

	a_push_credit: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		push |-> have_credit);

endmodule

`default_nettype wire

/* source/write_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module write_fifo
	import axi_regs_pkg::*;
(
	input wire logic s00_axi_aclk,
	input wire logic arst_n,
	input wire logic push,
	input wire write_req_t wr_req,
	input wire logic pop,
	output write_req_t head,
	output logic not_empty
);

	localparam int ptr_width = $clog2(wr_buf_depth);

	write_req_t mem [wr_buf_depth];

	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [credit_width-1:0] count;

	assign not_empty = (count != '0);
	assign head = mem[rd_ptr];

	always_ff @(posedge s00_axi_aclk) begin
		if (push)
			mem[wr_ptr] <= wr_req;
	end

	// depth is a power of two, so the pointers wrap by themselves.
	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the front end credits are what keep this from overflowing.
	a_no_overflow: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		push |-> (count != credit_width'(wr_buf_depth)) || pop);

	a_no_underflow: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		pop |-> not_empty);

endmodule

`default_nettype wire

/* source/reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_bank
	import axi_regs_pkg::*;
(
	input wire logic s00_axi_aclk,
	input wire logic arst_n,
	input wire write_req_t head,
	input wire logic not_empty,
	output logic pop,
	output logic commit,
	input wire logic [addr_width-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire logic rready
);

	logic [data_width-1:0] regs [reg_count];

	logic ar_hs;
	logic r_hs;
	reg_index_t rd_index;

	// one write per cycle, taken as soon as the buffer shows it.
	assign pop = not_empty;
	assign commit = pop;

	assign arready = !rvalid;
	assign ar_hs = arvalid && arready;
	assign r_hs = rvalid && rready;
	assign rd_index = reg_index_t'(araddr[addr_width-1:2]);
	assign rresp = axi_resp_okay;

	// only the bytes with their strobe set are replaced.
	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < reg_count; r++)
				regs[r] <= '0;
		end else if (pop) begin
			for (int b = 0; b < strb_width; b++) begin
				if (head.strb[b])
					regs[head.index][8*b +: 8] <= head.data[8*b +: 8];
			end
		end
	end

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n)
			rvalid <= 1'b0;
		else if (ar_hs)
			rvalid <= 1'b1;
		else if (r_hs)
			rvalid <= 1'b0;
	end

	// data is sampled at the AR handshake and held until R completes.
	always_ff @(posedge s00_axi_aclk) begin
		if (ar_hs)
			rdata <= regs[rd_index];
	end

	a_rdata_hold: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* source/axi_lite_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs
	import axi_regs_pkg::*;
(
	input wire logic s00_axi_aclk,
	input wire logic arst_n,
	input wire logic [addr_width-1:0] s00_axi_awaddr,
	input wire logic s00_axi_awvalid,
	output logic s00_axi_awready,
	input wire logic [data_width-1:0] s00_axi_wdata,
	input wire logic [strb_width-1:0] s00_axi_wstrb,
	input wire logic s00_axi_wvalid,
	output logic s00_axi_wready,
	output logic [1:0] s00_axi_bresp,
	output logic s00_axi_bvalid,
	input wire logic s00_axi_bready,
	input wire logic [addr_width-1:0] s00_axi_araddr,
	input wire logic s00_axi_arvalid,
	output logic s00_axi_arready,
	output logic [data_width-1:0] s00_axi_rdata,
	output logic [1:0] s00_axi_rresp,
	output logic s00_axi_rvalid,
	input wire logic s00_axi_rready
);

	write_req_t wr_req;
	write_req_t head;
	logic push;
	logic pop;
	logic not_empty;
	logic commit; // one pulse per register update, counted as a pending response.

	axi_write_front u_front (
		.s00_axi_aclk (s00_axi_aclk),
		.arst_n (arst_n),
		.awaddr (s00_axi_awaddr),
		.awvalid (s00_axi_awvalid),
		.awready (s00_axi_awready),
		.wdata (s00_axi_wdata),
		.wstrb (s00_axi_wstrb),
		.wvalid (s00_axi_wvalid),
		.wready (s00_axi_wready),
		.bresp (s00_axi_bresp),
		.bvalid (s00_axi_bvalid),
		.bready (s00_axi_bready),
		.commit (commit),
		.wr_req (wr_req),
		.push (push)
	);

	write_fifo u_fifo (
		.s00_axi_aclk (s00_axi_aclk),
		.arst_n (arst_n),
		.push (push),
		.wr_req (wr_req),
		.pop (pop),
		.head (head),
		.not_empty (not_empty)
	);

	reg_bank u_regs (
		.s00_axi_aclk (s00_axi_aclk),
		.arst_n (arst_n),
		.head (head),
		.not_empty (not_empty),
		.pop (pop),
		.commit (commit),
		.araddr (s00_axi_araddr),
		.arvalid (s00_axi_arvalid),
		.arready (s00_axi_arready),
		.rdata (s00_axi_rdata),
		.rresp (s00_axi_rresp),
		.rvalid (s00_axi_rvalid),
		.rready (s00_axi_rready)
	);

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic s00_axi_aclk
);

	initial begin
		s00_axi_aclk = 1'b0;
		forever
			#20 s00_axi_aclk = ~s00_axi_aclk; // half of the 40 ns period.
	end

endmodule

`default_nettype wire

/* test/tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb
	import axi_regs_pkg::*;
();

	localparam int wait_limit = 64; // cycles a single wait may take.
	localparam int stall_window = 12;

	logic s00_axi_aclk;
	logic arst_n;
	logic [addr_width-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [data_width-1:0] wdata;
	logic [strb_width-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [addr_width-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [data_width-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int error_count;
	int tests_run;
	int tests_failed;
	bit stalled;
	int aw_open; // AW handshakes not yet answered on B.
	int w_open;
	logic [data_width-1:0] exp_rdata;
	logic [7:0] model_bytes [reg_count*strb_width];
	write_req_t model_q [$];

	clock_gen u_clk (
		.s00_axi_aclk (s00_axi_aclk)
	);

	axi_lite_regs dut (
		.s00_axi_aclk (s00_axi_aclk),
		.arst_n (arst_n),
		.s00_axi_awaddr (awaddr),
		.s00_axi_awvalid (awvalid),
		.s00_axi_awready (awready),
		.s00_axi_wdata (wdata),
		.s00_axi_wstrb (wstrb),
		.s00_axi_wvalid (wvalid),
		.s00_axi_wready (wready),
		.s00_axi_bresp (bresp),
		.s00_axi_bvalid (bvalid),
		.s00_axi_bready (bready),
		.s00_axi_araddr (araddr),
		.s00_axi_arvalid (arvalid),
		.s00_axi_arready (arready),
		.s00_axi_rdata (rdata),
		.s00_axi_rresp (rresp),
		.s00_axi_rvalid (rvalid),
		.s00_axi_rready (rready)
	);

	function automatic void note_error(input string msg);
		error_count++;
		$display("error at %0t: %s", $time, msg);
	endfunction

	function automatic void note_stall(input string channel);
		if (!stalled)
			$display("timeout: the %s channel made no handshake in %0d cycles", channel, wait_limit);
		stalled = 1'b1;
	endfunction

	function automatic logic [addr_width-1:0] reg_addr(input int index);
		logic [1:0] low;
		low = 2'($urandom()); // the DUT ignores the byte offset.
		return {reg_index_t'(index), low};
	endfunction

	function automatic logic [data_width-1:0] expected_word(input reg_index_t index);
		logic [data_width-1:0] word;
		for (int b = 0; b < strb_width; b++)
			word[8*b +: 8] = model_bytes[index*strb_width + b];
		return word;
	endfunction

	// the model takes each write when its response is accepted, in issue order.
	always @(posedge s00_axi_aclk or negedge arst_n) begin
		write_req_t done;
		if (!arst_n) begin
			aw_open <= 0;
			w_open <= 0;
		end else begin
			aw_open <= aw_open + int'(awvalid && awready) - int'(bvalid && bready);
			w_open <= w_open + int'(wvalid && wready) - int'(bvalid && bready);
			if (bvalid && bready && model_q.size() != 0) begin
				done = model_q.pop_front();
				for (int b = 0; b < strb_width; b++)
					if (done.strb[b])
						model_bytes[done.index*strb_width + b] <= done.data[8*b +: 8];
			end
		end
	end

	a_reset_idle: assert property (@(posedge s00_axi_aclk)
		$rose(arst_n) |-> !bvalid && !rvalid && awready && wready && arready)
		else note_error("outputs not idle after reset");

	a_bresp_okay: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		bvalid |-> bresp == axi_resp_okay) else note_error("bresp is not OKAY");

	a_rresp_okay: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		rvalid |-> rresp == axi_resp_okay) else note_error("rresp is not OKAY");

	a_b_hold: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else note_error("B response dropped or changed before bready");

	a_r_hold: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else note_error("R response dropped or changed before rready");

	a_rdata_model: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		rvalid |-> rdata == exp_rdata)
		else note_error($sformatf("rdata %h, expected %h", rdata, exp_rdata));

	a_arready: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		arready == !rvalid) else note_error("arready does not follow rvalid");

	// every credit in use means no further address or data is taken.
	a_aw_credit: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		aw_open >= wr_buf_depth |-> !awready) else note_error("awready high with no credit");

	a_w_credit: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		w_open >= wr_buf_depth |-> !wready) else note_error("wready high with no credit");

	a_no_extra_b: assert property (@(posedge s00_axi_aclk) disable iff (!arst_n)
		aw_open == 0 |-> !bvalid) else note_error("B response with no write outstanding");

	task automatic next_cycle();
		@(posedge s00_axi_aclk);
		#2;
	endtask

	task automatic send_aw(input logic [addr_width-1:0] addr);
		int cyc;
		cyc = 0;
		awaddr = addr;
		awvalid = 1'b1;
		while (!awready && !stalled && cyc < wait_limit) begin
			next_cycle();
			cyc++;
		end
		if (!awready)
			note_stall("write address");
		else
			next_cycle();
		awvalid = 1'b0;
	endtask

	task automatic send_w(input logic [data_width-1:0] data, input logic [strb_width-1:0] strb);
		int cyc;
		cyc = 0;
		wdata = data;
		wstrb = strb;
		wvalid = 1'b1;
		while (!wready && !stalled && cyc < wait_limit) begin
			next_cycle();
			cyc++;
		end
		if (!wready)
			note_stall("write data");
		else
			next_cycle();
		wvalid = 1'b0;
	endtask

	// order 0 sends AW first, 1 sends W first, anything else sends both at once.
	task automatic issue_write(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data, input logic [strb_width-1:0] strb, input int order);
		write_req_t req;
		req = '{index: reg_index_t'(addr[addr_width-1:2]), data: data, strb: strb};
		model_q.push_back(req);
		case (order)
			0: begin
				send_aw(addr);
				send_w(data, strb);
			end
			1: begin
				send_w(data, strb);
				send_aw(addr);
			end
			default: fork
				send_aw(addr);
				send_w(data, strb);
			join
		endcase
	endtask

	task automatic wait_bresp();
		int cyc;
		cyc = 0;
		bready = 1'b1;
		while (!bvalid && !stalled && cyc < wait_limit) begin
			next_cycle();
			cyc++;
		end
		if (!bvalid)
			note_stall("write response");
		else
			next_cycle();
		bready = 1'b0;
	endtask

	task automatic write_reg(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data, input logic [strb_width-1:0] strb, input int order);
		issue_write(addr, data, strb, order);
		wait_bresp();
	endtask

	task automatic read_reg(input logic [addr_width-1:0] addr, input int hold);
		int cyc;
		exp_rdata = expected_word(reg_index_t'(addr[addr_width-1:2]));
		araddr = addr;
		arvalid = 1'b1;
		cyc = 0;
		while (!arready && !stalled && cyc < wait_limit) begin
			next_cycle();
			cyc++;
		end
		if (!arready)
			note_stall("read address");
		else
			next_cycle();
		arvalid = 1'b0;
		cyc = 0;
		while (!rvalid && !stalled && cyc < wait_limit) begin
			next_cycle();
			cyc++;
		end
		if (!rvalid) begin
			note_stall("read data");
		end else begin
			repeat (hold) next_cycle(); // rready low keeps the response waiting.
			rready = 1'b1;
			next_cycle();
			rready = 1'b0;
		end
	endtask

	task automatic run_backpressure();
		int cyc;
		bready = 1'b0;
		for (int i = 0; i < wr_buf_depth; i++)
			issue_write(reg_addr(i % reg_count), $urandom(), strb_width'($urandom()), 2);
		// one more write has to wait until responses are taken.
		fork
			issue_write(reg_addr($urandom() % reg_count), $urandom(), 4'hf, $urandom() % 3);
			begin
				repeat (stall_window) next_cycle();
				assert (aw_open == wr_buf_depth)
					else note_error("write accepted with every credit in use");
				bready = 1'b1;
			end
		join
		cyc = 0;
		while (aw_open != 0 && !stalled && cyc < wait_limit) begin
			next_cycle();
			cyc++;
		end
		if (aw_open != 0)
			note_stall("write response");
		bready = 1'b0;
		for (int r = 0; r < reg_count; r++)
			read_reg(reg_addr(r), 0);
	endtask

	task automatic close_test(input string name, input int errors_before);
		repeat (2) next_cycle();
		tests_run++;
		if (stalled || error_count != errors_before) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	initial begin
		int mark;
		int idx;
		void'($urandom(32'he0d6));
		arst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		stalled = 1'b0;
		exp_rdata = '0;
		for (int i = 0; i < reg_count*strb_width; i++)
			model_bytes[i] = 8'h00;
		repeat (16) @(posedge s00_axi_aclk);
		#2;
		arst_n = 1'b1;
		next_cycle();

		mark = error_count;
		for (int r = 0; r < reg_count; r++)
			read_reg(reg_addr(r), 0);
		close_test("reset state", mark);

		mark = error_count;
		for (int r = 0; r < reg_count; r++) begin
			write_reg(reg_addr(r), $urandom(), 4'hf, 2);
			read_reg(reg_addr(r), 0);
		end
		close_test("full strobe", mark);

		mark = error_count;
		write_reg(reg_addr(0), 32'h12345678, 4'hf, 2);
		write_reg(reg_addr(0), $urandom(), 4'b1000, 2);
		read_reg(reg_addr(0), 0);
		for (int i = 0; i < 6; i++) begin
			idx = $urandom() % reg_count;
			write_reg(reg_addr(idx), $urandom(), strb_width'($urandom()), 2);
			read_reg(reg_addr(idx), 0);
		end
		close_test("partial strobe", mark);

		mark = error_count;
		for (int order = 0; order < 3; order++) begin
			write_reg(reg_addr(order + 1), $urandom(), 4'hf, order);
			read_reg(reg_addr(order + 1), 0);
		end
		for (int i = 0; i < 6; i++) begin
			idx = $urandom() % reg_count;
			write_reg(reg_addr(idx), $urandom(), strb_width'($urandom()), $urandom() % 3);
			read_reg(reg_addr(idx), 0);
		end
		close_test("channel order", mark);

		mark = error_count;
		run_backpressure();
		close_test("write back-pressure", mark);

		mark = error_count;
		write_reg(reg_addr(2), $urandom(), 4'hf, 2);
		read_reg(reg_addr(2), 6);
		read_reg(reg_addr(3), 3);
		close_test("read hold", mark);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (stalled || error_count != 0 || tests_failed != 0)
			$display("Checks failed");
		else
			$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
source/axi_regs_pkg.sv
source/axi_write_front.sv
source/write_fifo.sv
source/reg_bank.sv
source/axi_lite_regs.sv
test/clock_gen.sv
test/tb.sv

/* Bender.yml */
package:
  name: axi_lite_regs

sources:
  - source/axi_regs_pkg.sv
  - source/axi_write_front.sv
  - source/write_fifo.sv
  - source/reg_bank.sv
  - source/axi_lite_regs.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/tb.sv
